//--- logic/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

    // Opcode in ir[7:4]
    typedef enum logic [3:0] {
        op_add  = 4'd1,
        op_sub  = 4'd2,
        op_and  = 4'd3,
        op_inc  = 4'd4,
        op_ld   = 4'd5,
        op_st   = 4'd6,
        op_jc   = 4'd7,
        op_jz   = 4'd8,
        op_jmp  = 4'd9,
        op_out  = 4'd10,
        op_iret = 4'd11, // No longer serviced, decodes as unused
        op_or   = 4'd12,
        op_xor  = 4'd13,
        op_stp  = 4'd14
    } opcode_t;

    // Front panel switches
    typedef enum logic [2:0] {
        mode_run    = 3'd0,
        mode_mem_wr = 3'd1,
        mode_mem_rd = 3'd2,
        mode_reg_rd = 3'd3,
        mode_reg_wr = 3'd4
    } panel_mode_t;

    // One-hot beat phases from the sequencer
    typedef struct packed {
        logic w3;
        logic w2;
        logic w1;
    } beat_t;

    typedef struct packed {
        logic       ldc;
        logic       ldz;
        logic       cin;
        logic       m;
        logic       abus;
        logic       drw;
        logic       pcinc;
        logic       lpc;
        logic       lar;
        logic       pcadd;
        logic       arinc;
        logic       selctl;
        logic       memw;
        logic       stop;
        logic       lir;
        logic       sbus;
        logic       mbus;
        logic       short_cyc;
        logic       long_cyc;
        logic [3:0] s;   // ALU function
        logic [3:0] sel; // Register select
    } ctrl_word_t;

    // Sub and xor share one ALU encoding
    typedef logic [3:0] alu_fn_t;

    localparam alu_fn_t alu_add    = 4'b1001;
    localparam alu_fn_t alu_sub    = 4'b0110;
    localparam alu_fn_t alu_and    = 4'b1011;
    localparam alu_fn_t alu_inc    = 4'b0000;
    localparam alu_fn_t alu_pass_b = 4'b1010;
    localparam alu_fn_t alu_pass_a = 4'b1111;
    localparam alu_fn_t alu_or     = 4'b1110;
    localparam alu_fn_t alu_xor    = 4'b0110;

endpackage

//--- logic/instr_decode.sv
`timescale 1ns/1ps

module instr_decode (
    input  cpu_ctrl_pkg::opcode_t    ir,
    input  cpu_ctrl_pkg::beat_t      w,
    input  logic                     c,
    input  logic                     z,
    output cpu_ctrl_pkg::ctrl_word_t run_word
);

    always_comb begin
        run_word = '0;

        // Fetch on the first beat for every opcode
        run_word.lir   = w.w1;
        run_word.pcinc = w.w1;

        case (ir)
            cpu_ctrl_pkg::op_add: begin
                run_word.s    = cpu_ctrl_pkg::alu_add;
                run_word.cin  = w.w2;
                run_word.abus = w.w2;
                run_word.drw  = w.w2;
                run_word.ldz  = w.w2;
                run_word.ldc  = w.w2;
            end
            cpu_ctrl_pkg::op_sub: begin
                run_word.s    = cpu_ctrl_pkg::alu_sub;
                run_word.abus = w.w2;
                run_word.drw  = w.w2;
                run_word.ldz  = w.w2;
                run_word.ldc  = w.w2;
            end
            cpu_ctrl_pkg::op_and: begin
                run_word.s    = cpu_ctrl_pkg::alu_and;
                run_word.m    = w.w2;
                run_word.abus = w.w2;
                run_word.drw  = w.w2;
                run_word.ldz  = w.w2;
            end
            cpu_ctrl_pkg::op_inc: begin
                run_word.s    = cpu_ctrl_pkg::alu_inc;
                run_word.abus = w.w2;
                run_word.drw  = w.w2;
                run_word.ldz  = w.w2;
                run_word.ldc  = w.w2;
            end
            cpu_ctrl_pkg::op_ld: begin
                run_word.s        = cpu_ctrl_pkg::alu_pass_b;
                run_word.m        = w.w2;
                run_word.abus     = w.w2; // Address onto the bus
                run_word.lar      = w.w2;
                run_word.long_cyc = w.w2;
                run_word.drw      = w.w3; // Memory data into register
                run_word.mbus     = w.w3;
            end
            cpu_ctrl_pkg::op_st: begin
                // Pass A for the address, then pass B for the data
                run_word.s        = {1'b1, w.w2, 1'b1, w.w2};
                run_word.m        = w.w2 | w.w3;
                run_word.abus     = w.w2 | w.w3;
                run_word.lar      = w.w2;
                run_word.long_cyc = w.w2;
                run_word.memw     = w.w3;
            end
            cpu_ctrl_pkg::op_jc: begin
                run_word.pcadd = w.w2 & c;
            end
            cpu_ctrl_pkg::op_jz: begin
                run_word.pcadd = w.w2 & z;
            end
            cpu_ctrl_pkg::op_jmp: begin
                run_word.s    = cpu_ctrl_pkg::alu_pass_a;
                run_word.m    = w.w2;
                run_word.abus = w.w2;
                run_word.lpc  = w.w2;
            end
            cpu_ctrl_pkg::op_out: begin
                run_word.s    = cpu_ctrl_pkg::alu_pass_b;
                run_word.m    = w.w2;
                run_word.abus = w.w2;
            end
            cpu_ctrl_pkg::op_or: begin
                run_word.s    = cpu_ctrl_pkg::alu_or;
                run_word.m    = w.w2;
                run_word.abus = w.w2;
                run_word.drw  = w.w2;
                run_word.ldz  = w.w2;
            end
            cpu_ctrl_pkg::op_xor: begin
                run_word.s    = cpu_ctrl_pkg::alu_xor;
                run_word.m    = w.w2;
                run_word.abus = w.w2;
                run_word.drw  = w.w2;
                run_word.ldz  = w.w2;
            end
            cpu_ctrl_pkg::op_stp: begin
                run_word.stop = w.w2;
            end
            default: begin
                // IRET and unused codes only fetch
                run_word.s = 4'b0000;
            end
        endcase
    end

endmodule

//--- logic/panel_sequencer.sv
`timescale 1ns/1ps

module panel_sequencer (
    input  logic                      t3,
    input  logic                      arst_n,
    input  cpu_ctrl_pkg::panel_mode_t sw,
    input  cpu_ctrl_pkg::beat_t       w,
    input  cpu_ctrl_pkg::ctrl_word_t  run_word,
    output cpu_ctrl_pkg::ctrl_word_t  ctrl
);

    logic st0; // Second step of a console operation

    always_ff @(posedge t3 or negedge arst_n) begin
        if (!arst_n) begin
            st0 <= 1'b0;
        end else begin
            case (sw)
                cpu_ctrl_pkg::mode_mem_wr: begin
                    if (w.w1)
                        st0 <= 1'b1;
                end
                cpu_ctrl_pkg::mode_mem_rd: begin
                    if (w.w1 && !st0)
                        st0 <= 1'b1;
                end
                cpu_ctrl_pkg::mode_reg_wr: begin
                    if (w.w2)
                        st0 <= !st0; // Alternate between register pairs
                end
                default: st0 <= st0;
            endcase
        end
    end

    always_comb begin
        ctrl = '0;

        case (sw)
            cpu_ctrl_pkg::mode_run: begin
                ctrl = run_word;
            end
            cpu_ctrl_pkg::mode_mem_wr: begin
                ctrl.lar       = w.w1 & !st0; // Load start address
                ctrl.memw      = w.w1 & st0;
                ctrl.arinc     = w.w1 & st0;
                ctrl.sbus      = w.w1;
                ctrl.stop      = w.w1;
                ctrl.short_cyc = w.w1;
                ctrl.selctl    = w.w1;
            end
            cpu_ctrl_pkg::mode_mem_rd: begin
                ctrl.sbus      = w.w1 & !st0;
                ctrl.lar       = w.w1 & !st0;
                ctrl.mbus      = w.w1 & st0;
                ctrl.arinc     = w.w1 & st0;
                ctrl.stop      = w.w1;
                ctrl.short_cyc = w.w1;
                ctrl.selctl    = w.w1;
            end
            cpu_ctrl_pkg::mode_reg_rd: begin
                ctrl.selctl = w.w1 | w.w2;
                ctrl.stop   = w.w1 | w.w2;
                // R0/R1 on w1, R2/R3 on w2
                ctrl.sel    = {w.w2, 1'b0, w.w2, w.w1 | w.w2};
            end
            cpu_ctrl_pkg::mode_reg_wr: begin
                ctrl.sbus   = w.w1 | w.w2;
                ctrl.selctl = w.w1 | w.w2;
                ctrl.drw    = w.w1 | w.w2;
                ctrl.stop   = w.w1 | w.w2;
                ctrl.sel[3] = st0;
                ctrl.sel[2] = w.w2;
                ctrl.sel[1] = (!st0 & w.w1) | (st0 & w.w2);
                ctrl.sel[0] = w.w1;
            end
            default: begin
                // Undefined switch settings stay idle
                ctrl = '0;
            end
        endcase
    end

endmodule

//--- logic/hdcpu_ctrl.sv
`timescale 1ns/1ps

module hdcpu_ctrl (
    input  logic                      t3,
    input  logic                      arst_n,
    input  cpu_ctrl_pkg::panel_mode_t sw,
    input  cpu_ctrl_pkg::opcode_t     ir,
    input  cpu_ctrl_pkg::beat_t       w,
    input  logic                      c,
    input  logic                      z,
    output cpu_ctrl_pkg::ctrl_word_t  ctrl
);

    cpu_ctrl_pkg::ctrl_word_t run_word; // Run mode control word

    instr_decode u_instr_decode (
        .ir       (ir),
        .w        (w),
        .c        (c),
        .z        (z),
        .run_word (run_word)
    );

    // Console modes override the decoder
    panel_sequencer u_panel_sequencer (
        .t3       (t3),
        .arst_n   (arst_n),
        .sw       (sw),
        .w        (w),
        .run_word (run_word),
        .ctrl     (ctrl)
    );

endmodule

//--- verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    localparam time half_period = 50ns; // 100 ns period

    initial begin
        clk = 1'b0;
        forever begin
            #half_period;
            clk = ~clk;
        end
    end

endmodule

//--- verif/ctrl_model.svh
`ifndef CTRL_MODEL_SVH
`define CTRL_MODEL_SVH

// Expected run-mode word from the opcode table
function automatic cpu_ctrl_pkg::ctrl_word_t expected_run_word(
    input cpu_ctrl_pkg::opcode_t op,
    input cpu_ctrl_pkg::beat_t   beat,
    input logic                  flag_c,
    input logic                  flag_z
);
    cpu_ctrl_pkg::ctrl_word_t e;
    logic b2;
    logic b3;
    e  = '0;
    b2 = beat.w2;
    b3 = beat.w3;
    {e.lir, e.pcinc} = {2{beat.w1}}; // Fetch beat
    case (op)
        cpu_ctrl_pkg::op_add: begin
            e.s = cpu_ctrl_pkg::alu_add;
            {e.cin, e.abus, e.drw, e.ldz, e.ldc} = {5{b2}};
        end
        cpu_ctrl_pkg::op_sub: begin
            e.s = cpu_ctrl_pkg::alu_sub;
            {e.abus, e.drw, e.ldz, e.ldc} = {4{b2}};
        end
        cpu_ctrl_pkg::op_and: begin
            e.s = cpu_ctrl_pkg::alu_and;
            {e.m, e.abus, e.drw, e.ldz} = {4{b2}};
        end
        cpu_ctrl_pkg::op_inc: begin
            e.s = cpu_ctrl_pkg::alu_inc;
            {e.abus, e.drw, e.ldz, e.ldc} = {4{b2}};
        end
        cpu_ctrl_pkg::op_ld: begin
            e.s = cpu_ctrl_pkg::alu_pass_b;
            {e.m, e.abus, e.lar, e.long_cyc} = {4{b2}};
            {e.drw, e.mbus} = {2{b3}};
        end
        cpu_ctrl_pkg::op_st: begin
            e.s = {1'b1, b2, 1'b1, b2};
            {e.m, e.abus} = {2{b2 | b3}};
            {e.lar, e.long_cyc} = {2{b2}};
            e.memw = b3;
        end
        cpu_ctrl_pkg::op_jc:  e.pcadd = b2 & flag_c;
        cpu_ctrl_pkg::op_jz:  e.pcadd = b2 & flag_z;
        cpu_ctrl_pkg::op_jmp: begin
            e.s = cpu_ctrl_pkg::alu_pass_a;
            {e.m, e.abus, e.lpc} = {3{b2}};
        end
        cpu_ctrl_pkg::op_out: begin
            e.s = cpu_ctrl_pkg::alu_pass_b;
            {e.m, e.abus} = {2{b2}};
        end
        cpu_ctrl_pkg::op_or: begin
            e.s = cpu_ctrl_pkg::alu_or;
            {e.m, e.abus, e.drw, e.ldz} = {4{b2}};
        end
        cpu_ctrl_pkg::op_xor: begin
            e.s = cpu_ctrl_pkg::alu_xor;
            {e.m, e.abus, e.drw, e.ldz} = {4{b2}};
        end
        cpu_ctrl_pkg::op_stp: e.stop = b2;
        default: e.s = 4'b0000; // IRET and unused codes only fetch
    endcase
    return e;
endfunction

// Final word after the panel switch selection
function automatic cpu_ctrl_pkg::ctrl_word_t expected_ctrl(
    input cpu_ctrl_pkg::panel_mode_t mode,
    input cpu_ctrl_pkg::beat_t       beat,
    input cpu_ctrl_pkg::opcode_t     op,
    input logic                      flag_c,
    input logic                      flag_z,
    input logic                      step
);
    cpu_ctrl_pkg::ctrl_word_t e;
    logic a1;
    logic a12;
    e   = '0;
    a1  = beat.w1;
    a12 = beat.w1 | beat.w2;
    case (mode)
        cpu_ctrl_pkg::mode_run: e = expected_run_word(op, beat, flag_c, flag_z);
        cpu_ctrl_pkg::mode_mem_wr: begin
            e.lar = a1 & !step;
            {e.memw, e.arinc} = {2{a1 & step}};
            {e.sbus, e.stop, e.short_cyc, e.selctl} = {4{a1}};
        end
        cpu_ctrl_pkg::mode_mem_rd: begin
            {e.sbus, e.lar} = {2{a1 & !step}};
            {e.mbus, e.arinc} = {2{a1 & step}};
            {e.stop, e.short_cyc, e.selctl} = {3{a1}};
        end
        cpu_ctrl_pkg::mode_reg_rd: begin
            {e.selctl, e.stop} = {2{a12}};
            e.sel = {beat.w2, 1'b0, beat.w2, a12};
        end
        cpu_ctrl_pkg::mode_reg_wr: begin
            {e.sbus, e.selctl, e.drw, e.stop} = {4{a12}};
            e.sel = {step, beat.w2, (!step & a1) | (step & beat.w2), a1};
        end
        default: e = '0;
    endcase
    return e;
endfunction

// st0 after the next rising edge of t3
function automatic logic next_st0(
    input cpu_ctrl_pkg::panel_mode_t mode,
    input cpu_ctrl_pkg::beat_t       beat,
    input logic                      step
);
    if (mode == cpu_ctrl_pkg::mode_mem_wr && beat.w1)
        return 1'b1;
    if (mode == cpu_ctrl_pkg::mode_mem_rd && beat.w1 && !step)
        return 1'b1;
    if (mode == cpu_ctrl_pkg::mode_reg_wr && beat.w2)
        return !step; // Set or clear on each w2
    return step;
endfunction

task automatic compare_value(
    input string       name,
    input logic [26:0] got,
    input logic [26:0] exp
);
    if (got !== exp) begin
        $display("Error %s: got %h expected %h (cycle %0d)", name, got, exp, cycle_count);
        $display("sim failed");
        $fatal(1, "value mismatch on %s", name);
    end
endtask

`endif

//--- verif/tb_hdcpu_ctrl.sv
`timescale 1ns/1ps

module tb_hdcpu_ctrl;

    localparam int random_cycles = 1500;
    localparam int cycle_limit   = 2000; // About 315 directed cycles, random ones, margin

    logic                      t3;
    logic                      arst_n;
    cpu_ctrl_pkg::panel_mode_t sw;
    cpu_ctrl_pkg::opcode_t     ir;
    cpu_ctrl_pkg::beat_t       w;
    logic                      c;
    logic                      z;
    cpu_ctrl_pkg::ctrl_word_t  ctrl;

    logic   model_st0;
    int     cycle_count = 0;
    integer seed = 45491;

    `include "ctrl_model.svh"

    tb_clock u_tb_clock (.clk(t3));

    hdcpu_ctrl DUT (
        .t3     (t3),
        .arst_n (arst_n),
        .sw     (sw),
        .ir     (ir),
        .w      (w),
        .c      (c),
        .z      (z),
        .ctrl   (ctrl)
    );

    always @(posedge t3 or negedge arst_n) begin
        if (!arst_n)
            model_st0 <= 1'b0;
        else
            model_st0 <= next_st0(sw, w, model_st0);
    end

    always @(posedge t3) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("sim failed");
            $fatal(1, "cycle limit reached");
        end
    end

    // 0 idle, 1..3 select w1..w3
    function automatic cpu_ctrl_pkg::beat_t beat_from_index(input logic [3:0] k);
        case (k)
            4'd1:    return 3'b001;
            4'd2:    return 3'b010;
            4'd3:    return 3'b100;
            default: return 3'b000;
        endcase
    endfunction

    task automatic apply_and_check(
        input cpu_ctrl_pkg::panel_mode_t mode,
        input cpu_ctrl_pkg::opcode_t     op,
        input cpu_ctrl_pkg::beat_t       beat,
        input logic                      flag_c,
        input logic                      flag_z
    );
        @(posedge t3);
        #5;
        sw = mode;
        ir = op;
        w  = beat;
        c  = flag_c;
        z  = flag_z;
        @(negedge t3); // Inputs and st0 settled by mid cycle
        compare_value("ctrl", ctrl, expected_ctrl(sw, w, ir, c, z, model_st0));
        compare_value("st0", {26'd0, DUT.u_panel_sequencer.st0}, {26'd0, model_st0});
    endtask

    // Eight beats, one hex digit each, leftmost first
    task automatic run_console(input cpu_ctrl_pkg::panel_mode_t mode, input logic [31:0] beats);
        for (int i = 7; i >= 0; i--)
            apply_and_check(mode, cpu_ctrl_pkg::op_add, beat_from_index(beats[4*i +: 4]),
                            1'b0, 1'b0);
    endtask

    task automatic pulse_reset(input int cycles);
        @(posedge t3);
        #5;
        arst_n = 1'b0;
        repeat (cycles) @(posedge t3);
        #5;
        arst_n = 1'b1;
    endtask

    initial begin
        logic [31:0] r;
        arst_n = 1'b0;
        sw     = cpu_ctrl_pkg::mode_run;
        ir     = cpu_ctrl_pkg::opcode_t'(4'd0);
        w      = '0;
        c      = 1'b0;
        z      = 1'b0;
        repeat (10) @(posedge t3);
        #5;
        arst_n = 1'b1;

        // Unused opcode so the whole word is zero without beats
        for (int m = 0; m < 8; m++)
            apply_and_check(cpu_ctrl_pkg::panel_mode_t'(m[2:0]),
                            cpu_ctrl_pkg::opcode_t'(4'd0), '0, 0, 0);

        // Every opcode, every beat, every flag pair
        for (int op = 0; op < 16; op++)
            for (int b = 0; b < 4; b++)
                for (int f = 0; f < 4; f++)
                    apply_and_check(cpu_ctrl_pkg::mode_run, cpu_ctrl_pkg::opcode_t'(op[3:0]),
                                    beat_from_index(b[3:0]), f[1], f[0]);

        pulse_reset(2);
        run_console(cpu_ctrl_pkg::mode_mem_wr, 32'h1231_1011);
        pulse_reset(2);
        run_console(cpu_ctrl_pkg::mode_mem_rd, 32'h1213_1101);
        run_console(cpu_ctrl_pkg::mode_reg_rd, 32'h1230_2130);
        pulse_reset(2);
        run_console(cpu_ctrl_pkg::mode_reg_wr, 32'h1212_3212);

        for (int i = 0; i < random_cycles; i++) begin
            r = $random(seed);
            apply_and_check(cpu_ctrl_pkg::panel_mode_t'(r[2:0]), cpu_ctrl_pkg::opcode_t'(r[6:3]),
                            beat_from_index({2'b00, r[8:7]}), r[9], r[10]);
        end

        $display("sim passed");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+verif
logic/cpu_ctrl_pkg.sv
logic/instr_decode.sv
logic/panel_sequencer.sv
logic/hdcpu_ctrl.sv
verif/tb_clock.sv
verif/tb_hdcpu_ctrl.sv

//--- Makefile
# Verilator build and run for the control unit testbench

VERILATOR ?= verilator
TOP       ?= tb_hdcpu_ctrl
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= sim passed
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Result: PASS"; \
	else \
		echo "Result: FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
